// File: verilog/loader_pkg.sv
// Instruction encoding and load types shared by the boot loader
// Field layout follows the MIPS-like target with 7-bit instruction addresses
// Opcode and function values must match the external computer's decoder
package loader_pkg;

   // Primary opcodes in bits 31:26
   typedef enum logic [5:0] {
      OP_REG  = 6'd0,   // Register format, ALU op in funct
      OP_JMP  = 6'd2,   // Absolute jump
      OP_BGT  = 6'd7,   // Branch if greater than
      OP_ADDI = 6'd8,
      OP_SLTI = 6'd10,
      OP_ANDI = 6'd12,
      OP_ORI  = 6'd13,
      OP_XORI = 6'd14,
      OP_SLLI = 6'd15,
      OP_LW   = 6'd35,  // Load word from data memory
      OP_SW   = 6'd43   // Store word to data memory
   } opcode_e;

   // Function codes in bits 5:0 of register instructions
   typedef enum logic [5:0] {
      FN_NOP  = 6'd0,
      FN_SLLV = 6'd4,
      FN_JR   = 6'd8,   // Jump to address in source register
      FN_ADD  = 6'd32,
      FN_SUB  = 6'd34,
      FN_AND  = 6'd36,
      FN_OR   = 6'd37,
      FN_XOR  = 6'd38,
      FN_SLT  = 6'd42
   } funct_e;

   typedef logic [4:0] reg_addr_t;  // Register file index

   localparam reg_addr_t REG_ZERO = 5'd0;  // Hardwired zero
   localparam reg_addr_t REG_T0   = 5'd8;
   localparam reg_addr_t REG_T1   = 5'd9;
   localparam reg_addr_t REG_T2   = 5'd10;

   localparam logic [4:0] SHAMT_FILL = 5'b11111;  // Unused shift field in REG words

   // Data memory words of the C variables
   localparam logic [15:0] VAR_A    = 16'd0;
   localparam logic [15:0] VAR_B    = 16'd1;
   localparam logic [15:0] VAR_C    = 16'd2;
   localparam logic [15:0] VAR_D    = 16'd3;
   localparam logic [15:0] VAR_DPTR = 16'd4;  // Holds the address of D
   localparam logic [15:0] VAR_E    = 16'd5;
   localparam logic [15:0] VAR_F    = 16'd6;
   localparam logic [15:0] VAR_G    = 16'd7;
   localparam logic [15:0] VAR_H    = 16'd8;

   // Immediate  {op[31:26], rs[25:21], rt[20:16], imm[15:0]}
   // Register   {op, rs, rt, rd[15:11], shamt[10:6], funct[5:0]}
   // Jump       {op, target[25:0]}
   typedef logic [31:0] instr_t;

   typedef logic [6:0] imem_addr_t;  // 128-word instruction memory
   typedef logic       prog_sel_t;   // 0 C test, 1 every-operation
   typedef logic [6:0] prog_len_t;   // Word count of a program

   typedef enum logic [1:0] {
      LOAD_IDLE  = 2'd0,  // Waiting for a step press
      LOAD_WRITE = 2'd1,  // Streaming words to instruction memory
      LOAD_RUN   = 2'd2   // Computer enabled until reset
   } load_state_e;

   // One write beat toward instruction memory
   typedef struct packed {
      imem_addr_t addr;
      instr_t     word;
   } imem_wr_t;

endpackage

// File: verilog/step_detect.sv
// Step button front end; step_n is low when pressed and fully asynchronous
// No debounce here, so a bouncing button must be filtered outside
// start is a single-cycle pulse three edges after the press is sampled
module step_detect (
   input  logic                  clk,
   input  logic                  reset_sm,
   input  logic                  step_n,
   input  loader_pkg::prog_sel_t prog_sel,
   output logic                  start,
   output loader_pkg::prog_sel_t sel
);
   import loader_pkg::*;

   logic [1:0] sync_q;  // Two-flop synchronizer, [1] is the safe copy
   logic       prev_q;  // Level seen one cycle earlier
   logic       fall;    // High for one cycle on the press

   assign fall = prev_q & ~sync_q[1];

   always_ff @(posedge clk or negedge reset_sm) begin
      if (!reset_sm) begin
         sync_q <= 2'b11;  // Button released
         prev_q <= 1'b1;
         start  <= 1'b0;
         sel    <= '0;
      end else begin
         sync_q <= {sync_q[0], step_n};
         prev_q <= sync_q[1];
         start  <= fall;  // Edge register
         if (fall) begin
            sel <= prog_sel;  // Captured with the start pulse
         end
      end
   end

endmodule

// File: verilog/program_rom.sv
// Constant program tables, purely combinational lookup
// Indices at or past the selected length read as zero
module program_rom (
   input  loader_pkg::prog_sel_t  sel,
   input  loader_pkg::imem_addr_t rom_index,
   output loader_pkg::instr_t     rom_word,
   output loader_pkg::prog_len_t  rom_len
);
   import loader_pkg::*;

   localparam prog_len_t PROG0_LEN = 7'd27;
   localparam prog_len_t PROG1_LEN = 7'd25;

   // C test program
   localparam instr_t PROG0 [PROG0_LEN] = '{
      {OP_ADDI, REG_ZERO, REG_T0, 16'd7},                   // int A = 7
      {OP_SW,   REG_ZERO, REG_T0, VAR_A},
      {OP_ADDI, REG_ZERO, REG_T0, 16'd5},                   // int B = 5
      {OP_SW,   REG_ZERO, REG_T0, VAR_B},
      {OP_ADDI, REG_ZERO, REG_T0, 16'd2},                   // int C = 2
      {OP_SW,   REG_ZERO, REG_T0, VAR_C},
      {OP_ADDI, REG_ZERO, REG_T0, 16'd4},                   // int D = 4
      {OP_SW,   REG_ZERO, REG_T0, VAR_D},
      {OP_ADDI, REG_ZERO, REG_T0, VAR_D},                   // DPtr = &D
      {OP_SW,   REG_ZERO, REG_T0, VAR_DPTR},
      {OP_LW,   REG_ZERO, REG_T0, VAR_A},                   // if ((A - B) > 3)
      {OP_LW,   REG_ZERO, REG_T1, VAR_B},
      {OP_REG,  REG_T0, REG_T1, REG_T1, SHAMT_FILL, FN_SUB},
      {OP_ADDI, REG_ZERO, REG_T0, 16'd3},
      {OP_BGT,  REG_T0, REG_T1, 16'd6},                     // Skip to else
      {OP_ADDI, REG_ZERO, REG_T0, 16'd6},                   // C = 6
      {OP_SW,   REG_ZERO, REG_T0, VAR_C},
      {OP_LW,   REG_ZERO, REG_T0, VAR_D},                   // D = D << 2
      {OP_SLLI, REG_T0, REG_T0, 16'd2},
      {OP_SW,   REG_ZERO, REG_T0, VAR_D},
      {OP_JMP,  26'd27},                                    // Past the end
      {OP_LW,   REG_ZERO, REG_T0, VAR_C},                   // else C = C << 5
      {OP_SLLI, REG_T0, REG_T0, 16'd5},
      {OP_SW,   REG_ZERO, REG_T0, VAR_C},
      {OP_LW,   REG_ZERO, REG_T0, VAR_DPTR},                // *DPtr = 7
      {OP_ADDI, REG_ZERO, REG_T1, 16'd7},
      {OP_SW,   REG_T0, REG_T1, 16'd0}
   };

   // Every-operation program
   localparam instr_t PROG1 [PROG1_LEN] = '{
      {OP_ADDI, REG_ZERO, REG_T0, 16'd10},
      {OP_SW,   REG_ZERO, REG_T0, VAR_A},
      {OP_ADDI, REG_ZERO, REG_T0, 16'd3},
      {OP_SW,   REG_ZERO, REG_T0, VAR_B},
      {OP_LW,   REG_ZERO, REG_T0, VAR_A},
      {OP_LW,   REG_ZERO, REG_T1, VAR_B},
      {OP_REG,  REG_T0, REG_T1, REG_T2, SHAMT_FILL, FN_ADD},  // ALU ops
      {OP_REG,  REG_T0, REG_T1, REG_T2, SHAMT_FILL, FN_SUB},
      {OP_REG,  REG_T0, REG_T1, REG_T2, SHAMT_FILL, FN_AND},
      {OP_REG,  REG_T0, REG_T1, REG_T2, SHAMT_FILL, FN_OR},
      {OP_REG,  REG_T0, REG_T1, REG_T2, SHAMT_FILL, FN_XOR},
      {OP_REG,  REG_T0, REG_T1, REG_T2, SHAMT_FILL, FN_SLT},
      {OP_REG,  REG_T0, REG_T1, REG_T2, SHAMT_FILL, FN_SLLV},
      {OP_ADDI, REG_ZERO, REG_T0, 16'd18},                    // JR target
      {OP_REG,  REG_T0, REG_ZERO, REG_ZERO, SHAMT_FILL, FN_JR},
      {OP_REG,  REG_T0, REG_T1, REG_T2, SHAMT_FILL, FN_NOP},  // Jumped over
      {OP_REG,  REG_T0, REG_T1, REG_T2, SHAMT_FILL, FN_NOP},
      {OP_REG,  REG_T0, REG_T1, REG_T2, SHAMT_FILL, FN_NOP},
      {OP_REG,  REG_T0, REG_T1, REG_T2, SHAMT_FILL, FN_NOP},
      {OP_ADDI, REG_T0, REG_T2, 16'd3},                       // Immediate ops
      {OP_SLTI, REG_T0, REG_T2, 16'd3},
      {OP_ANDI, REG_T0, REG_T2, 16'd3},
      {OP_ORI,  REG_T0, REG_T2, 16'd3},
      {OP_XORI, REG_T0, REG_T2, 16'd3},
      {OP_SLLI, REG_T0, REG_T2, 16'd3}
   };

   always_comb begin
      rom_word = '0;  // Past the end
      if (sel == 1'b0) begin
         rom_len = PROG0_LEN;
         if (rom_index < PROG0_LEN) begin
            rom_word = PROG0[rom_index[4:0]];
         end
      end else begin
         rom_len = PROG1_LEN;
         if (rom_index < PROG1_LEN) begin
            rom_word = PROG1[rom_index[4:0]];
         end
      end
   end

endmodule

// File: verilog/load_sequencer.sv
// Idle, write and run sequence of the loader
// A program is loaded once per reset; presses after that are ignored
// run holds until reset_sm, the computer is never stopped by the loader
module load_sequencer (
   input  logic                   clk,
   input  logic                   reset_sm,
   input  logic                   start,
   input  loader_pkg::instr_t     rom_word,
   input  loader_pkg::prog_len_t  rom_len,
   input  logic                   can_send,
   input  logic                   drained,
   output loader_pkg::imem_addr_t rom_index,
   output logic                   send,
   output loader_pkg::imem_wr_t   beat,
   output logic                   comp_rst,
   output logic                   run
);
   import loader_pkg::*;

   load_state_e state;      // Sequence state
   imem_addr_t  idx;        // Next word to send
   logic        more_words; // Words left in the program

   assign more_words = (idx < rom_len);
   assign rom_index  = idx;

   // One beat per cycle while credits allow
   assign send       = (state == LOAD_WRITE) && more_words && can_send;
   assign beat.addr  = idx;       // Word lands at its own index
   assign beat.word  = rom_word;

   always_ff @(posedge clk or negedge reset_sm) begin
      if (!reset_sm) begin
         state    <= LOAD_IDLE;
         idx      <= '0;
         comp_rst <= 1'b0;
         run      <= 1'b0;
      end else begin
         comp_rst <= 1'b0;  // Single-cycle pulse
         case (state)
            LOAD_IDLE: begin
               if (start) begin
                  state    <= LOAD_WRITE;
                  idx      <= '0;
                  comp_rst <= 1'b1;  // Reset computer as writing begins
               end
            end
            LOAD_WRITE: begin
               if (send) begin
                  idx <= idx + 7'd1;
               end else if (!more_words && drained) begin
                  state <= LOAD_RUN;  // Every word accepted by memory
                  run   <= 1'b1;
               end
            end
            LOAD_RUN: begin
               run <= 1'b1;  // Held until reset
            end
            default: begin
               state <= LOAD_IDLE;
            end
         endcase
      end
   end

endmodule

// File: verilog/imem_write_port.sv
// Registered write port with credit flow control toward instruction memory
// Memory must accept every wr_valid beat and return exactly one credit per beat
// A credit arriving this cycle is not reused until the next cycle
module imem_write_port #(
   parameter int MAX_CREDITS = 4
) (
   input  logic                 clk,
   input  logic                 reset_sm,
   input  logic                 send,
   input  loader_pkg::imem_wr_t beat,
   input  logic                 wr_credit,
   output logic                 can_send,
   output logic                 drained,
   output logic                 wr_valid,
   output loader_pkg::imem_wr_t wr_beat
);
   import loader_pkg::*;

   localparam int CW = $clog2(MAX_CREDITS + 1);  // Counter holds 0 to MAX_CREDITS

   logic [CW-1:0] credits;  // Free credits, not yet counting wr_valid

   // Beat on the port this cycle still owns a counted credit
   assign can_send = wr_valid ? (credits > CW'(1)) : (credits != '0);
   assign drained  = (credits == CW'(MAX_CREDITS)) && !wr_valid;

   always_ff @(posedge clk or negedge reset_sm) begin
      if (!reset_sm) begin
         wr_valid <= 1'b0;
         credits  <= CW'(MAX_CREDITS);
      end else begin
         wr_valid <= send;
         case ({wr_valid, wr_credit})
            2'b10:   credits <= credits - CW'(1);  // Beat spent a credit
            2'b01:   credits <= credits + CW'(1);  // Memory returned one
            default: credits <= credits;           // Both or neither cancel
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (send) begin
         wr_beat <= beat;  // Payload only
      end
   end

endmodule

// File: verilog/program_loader_top.sv
// Boot loader top; one clock domain, computer and memory stay external
// prog_sel must be stable when the step button is pressed
module program_loader_top #(
   parameter int MAX_CREDITS = 4
) (
   input  logic                  clk,
   input  logic                  reset_sm,
   input  logic                  step_n,
   input  loader_pkg::prog_sel_t prog_sel,
   output logic                  comp_rst,
   output logic                  run,
   output logic                  wr_valid,
   output loader_pkg::imem_wr_t  wr_beat,
   input  logic                  wr_credit
);

   logic                   start;     // Press pulse
   loader_pkg::prog_sel_t  sel;       // Program captured on the press
   loader_pkg::imem_addr_t rom_index;
   loader_pkg::instr_t     rom_word;
   loader_pkg::prog_len_t  rom_len;
   logic                   send;      // Beat request to the port
   loader_pkg::imem_wr_t   beat;
   logic                   can_send;
   logic                   drained;

   step_detect i_step_detect (
      .clk      (clk),
      .reset_sm (reset_sm),
      .step_n   (step_n),
      .prog_sel (prog_sel),
      .start    (start),
      .sel      (sel)
   );

   program_rom i_program_rom (
      .sel       (sel),
      .rom_index (rom_index),
      .rom_word  (rom_word),
      .rom_len   (rom_len)
   );

   load_sequencer i_load_sequencer (
      .clk       (clk),
      .reset_sm  (reset_sm),
      .start     (start),
      .rom_word  (rom_word),
      .rom_len   (rom_len),
      .can_send  (can_send),
      .drained   (drained),
      .rom_index (rom_index),
      .send      (send),
      .beat      (beat),
      .comp_rst  (comp_rst),
      .run       (run)
   );

   imem_write_port #(
      .MAX_CREDITS (MAX_CREDITS)
   ) i_imem_write_port (
      .clk       (clk),
      .reset_sm  (reset_sm),
      .send      (send),
      .beat      (beat),
      .wr_credit (wr_credit),
      .can_send  (can_send),
      .drained   (drained),
      .wr_valid  (wr_valid),
      .wr_beat   (wr_beat)
   );

endmodule

// File: tests/tb_clock_gen.sv
// 4 ns clock and power-on reset held low for the first 4 rising edges
// hold_reset pulls reset_sm low again asynchronously while high
module tb_clock_gen (
   input  logic hold_reset,
   output logic clk,
   output logic reset_sm
);
   timeunit 1ns;
   timeprecision 100ps;

   logic por_done;  // Power-on reset finished

   assign reset_sm = por_done & ~hold_reset;

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   initial begin
      por_done = 1'b0;
      repeat (4) @(posedge clk);
      por_done <= 1'b1;  // Released on a rising edge
   end

endmodule

// File: tests/tb_program_loader.sv
// Memory model accepts every beat and returns its credit 0 to 6 cycles later
// Checks are concurrent assertions sampled on the rising edge of clk
// Word contents are compared only for C test beats 0 and 20 and every-operation beat 6
module tb_program_loader;
   timeunit 1ns;
   timeprecision 100ps;
   import loader_pkg::*;

   localparam int CREDITS    = 4;
   localparam int WAIT_LIMIT = 400;  // Cycles allowed per wait

   logic       clk;
   logic       reset_sm;
   logic       hold_reset;
   logic       step_n;
   prog_sel_t  prog_sel;
   logic       comp_rst;
   logic       run;
   logic       wr_valid;
   imem_wr_t   wr_beat;
   logic       wr_credit     = 1'b0;
   imem_wr_t   mem_q[$];                // Every accepted beat
   int         due_q[$];                // Earliest return cycle per owed credit
   int         cycle         = 0;
   int         outstanding   = 0;       // Beats sent minus credits returned
   logic       withhold;                // No credit returns while high
   prog_sel_t  cur_prog;                // Program the load should carry
   prog_len_t  exp_len;
   imem_addr_t exp_addr      = '0;      // Next beat address expected
   logic       comp_rst_seen = 1'b0;
   logic       comp_rst_d    = 1'b0;
   logic       run_d         = 1'b0;
   logic       reset_d       = 1'b0;
   int         value_errs    = 0;
   int         timeout_errs  = 0;

   assign exp_len = (cur_prog == 1'b1) ? prog_len_t'(25) : prog_len_t'(27);

   tb_clock_gen i_clock_gen (.hold_reset(hold_reset), .clk(clk), .reset_sm(reset_sm));

   program_loader_top #(.MAX_CREDITS(CREDITS)) i_dut (
      .clk(clk), .reset_sm(reset_sm), .step_n(step_n), .prog_sel(prog_sel),
      .comp_rst(comp_rst), .run(run), .wr_valid(wr_valid), .wr_beat(wr_beat),
      .wr_credit(wr_credit)
   );

   function automatic instr_t imm_word(opcode_e op, reg_addr_t rs, reg_addr_t rt,
                                       logic [15:0] imm);
      return (instr_t'(op) << 26) | (instr_t'(rs) << 21) | (instr_t'(rt) << 16) | instr_t'(imm);
   endfunction

   function automatic instr_t reg_word(reg_addr_t rs, reg_addr_t rt, reg_addr_t rd, funct_e fn);
      return (instr_t'(OP_REG) << 26) | (instr_t'(rs) << 21) | (instr_t'(rt) << 16)
           | (instr_t'(rd) << 11) | (instr_t'(SHAMT_FILL) << 6) | instr_t'(fn);
   endfunction

   function automatic instr_t jump_word(logic [25:0] target);
      return (instr_t'(OP_JMP) << 26) | instr_t'(target);
   endfunction

   task automatic note_error(input string msg);
      value_errs++;
      $display("Fail at %0t ns: %s", $time, msg);
   endtask

   // Instruction memory and reference counters
   always @(posedge clk) begin : memory_model
      int pick;
      pick       = -1;
      cycle     <= cycle + 1;
      comp_rst_d <= comp_rst;
      run_d      <= run;
      reset_d    <= reset_sm;
      if (!reset_sm) begin
         mem_q.delete();
         due_q.delete();
         outstanding   <= 0;
         exp_addr      <= '0;
         comp_rst_seen <= 1'b0;
         wr_credit     <= 1'b0;
      end else begin
         wr_credit <= 1'b0;
         if (comp_rst) comp_rst_seen <= 1'b1;
         if (wr_valid) begin
            mem_q.push_back(wr_beat);  // Accepted this cycle
            due_q.push_back(cycle + int'($urandom % 7));
            exp_addr <= exp_addr + 7'd1;
         end
         foreach (due_q[i]) begin
            if (pick < 0 && due_q[i] <= cycle) pick = i;
         end
         if (!withhold && pick >= 0) begin
            due_q.delete(pick);
            wr_credit <= 1'b1;  // One credit per cycle at most
         end
         outstanding <= outstanding + int'(wr_valid) - int'(wr_credit);
      end
   end

   reset_quiet: assert property (@(posedge clk)
      (reset_sm && reset_d) || (!comp_rst && !run && !wr_valid))
      else note_error("outputs active during reset or the cycle after");
   rst_single: assert property (@(posedge clk) !(comp_rst && comp_rst_d))
      else note_error("comp_rst high for more than one cycle");
   rst_once: assert property (@(posedge clk) disable iff (!reset_sm) !(comp_rst && comp_rst_seen))
      else note_error("comp_rst pulsed again after the load started");
   rst_first: assert property (@(posedge clk) disable iff (!reset_sm) !wr_valid || comp_rst_seen)
      else note_error("beat sent before comp_rst");
   beat_order: assert property (@(posedge clk) disable iff (!reset_sm)
      !wr_valid || (wr_beat.addr == exp_addr && exp_addr < exp_len))
      else note_error($sformatf("beat address %0d, expected %0d below %0d",
                                $sampled(wr_beat.addr), $sampled(exp_addr), $sampled(exp_len)));
   c_test_first: assert property (@(posedge clk) disable iff (!reset_sm)
      !(wr_valid && cur_prog == 1'b0 && wr_beat.addr == 7'd0)
      || wr_beat.word == imm_word(OP_ADDI, REG_ZERO, REG_T0, 16'd7))
      else note_error("C test beat 0 is not ADDI zero, t0, 7");
   c_test_jump: assert property (@(posedge clk) disable iff (!reset_sm)
      !(wr_valid && cur_prog == 1'b0 && wr_beat.addr == 7'd20)
      || wr_beat.word == jump_word(26'd27))
      else note_error("C test beat 20 is not JMP 27");
   ops_add: assert property (@(posedge clk) disable iff (!reset_sm)
      !(wr_valid && cur_prog == 1'b1 && wr_beat.addr == 7'd6)
      || wr_beat.word == reg_word(REG_T0, REG_T1, REG_T2, FN_ADD))
      else note_error("every-operation beat 6 is not ADD t0, t1, t2");
   credit_limit: assert property (@(posedge clk) disable iff (!reset_sm) outstanding <= CREDITS)
      else note_error("more beats outstanding than credits");
   run_rise: assert property (@(posedge clk) disable iff (!reset_sm)
      !(run && !run_d) || (exp_addr == exp_len && outstanding == 0))
      else note_error("run rose before every beat was sent and credited");
   run_hold: assert property (@(posedge clk) disable iff (!reset_sm) !run_d || run)
      else note_error("run fell without reset");
   run_quiet: assert property (@(posedge clk) !(run && wr_valid))
      else note_error("beat sent while run is high");

   task automatic wait_for_reset_release();
      int n;
      n = 0;
      while (reset_sm !== 1'b1 && n < 20) begin
         @(posedge clk);
         n++;
      end
      if (reset_sm !== 1'b1) begin
         timeout_errs++;
         $display("Timeout: reset_sm was never released");
      end
   endtask

   task automatic wait_for_beats(input int count);
      int n;
      n = 0;
      while (mem_q.size() < count && n < WAIT_LIMIT) begin
         @(posedge clk);
         n++;
      end
      if (mem_q.size() < count) begin
         timeout_errs++;
         $display("Timeout: only %0d of %0d beats arrived", mem_q.size(), count);
      end
   endtask

   task automatic wait_for_run();
      int n;
      n = 0;
      while (!run && n < WAIT_LIMIT) begin
         @(posedge clk);
         n++;
      end
      if (!run) begin
         timeout_errs++;
         $display("Timeout: run did not rise within %0d cycles", WAIT_LIMIT);
      end
   endtask

   task automatic press_step(input prog_sel_t which);
      @(posedge clk);
      prog_sel <= which;
      cur_prog <= which;
      @(posedge clk);
      step_n <= 1'b0;  // Pressed
      repeat (4) @(posedge clk);
      step_n <= 1'b1;
   endtask

   initial begin
      void'($urandom(54));
      hold_reset <= 1'b0;
      step_n     <= 1'b1;
      prog_sel   <= 1'b0;
      cur_prog   <= 1'b0;
      withhold   <= 1'b0;
      wait_for_reset_release();
      press_step(1'b0);  // C test program with a back-pressure window
      wait_for_beats(5);
      @(posedge clk);
      withhold <= 1'b1;
      repeat (20) @(posedge clk);
      assert (outstanding == CREDITS) else note_error("credits not used up under back-pressure");
      withhold <= 1'b0;
      wait_for_run();
      assert (mem_q.size() == 27) else note_error("C test load did not hold 27 beats");
      press_step(1'b0);  // Ignored while running
      repeat (20) @(posedge clk);
      assert (run && mem_q.size() == 27) else note_error("second press disturbed the load");
      @(posedge clk);
      hold_reset <= 1'b1;
      repeat (4) @(posedge clk);
      hold_reset <= 1'b0;
      wait_for_reset_release();
      press_step(1'b1);  // Every-operation program
      wait_for_run();
      assert (mem_q.size() == 25) else note_error("every-operation load did not hold 25 beats");
      repeat (5) @(posedge clk);
      $display("Errors: %0d wrong values, %0d timeouts", value_errs, timeout_errs);
      if (value_errs == 0 && timeout_errs == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

// File: src.f
verilog/loader_pkg.sv
verilog/step_detect.sv
verilog/program_rom.sv
verilog/load_sequencer.sv
verilog/imem_write_port.sv
verilog/program_loader_top.sv
tests/tb_clock_gen.sv
tests/tb_program_loader.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_program_loader
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Simulation FAILED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
